/* hdl/icu_pkg.sv */
//////////////////////////////////////////////////
// Integer execution cluster shared definitions
// Widths, ICU latency, opcodes, flags, request type
//////////////////////////////////////////////////

package icu_pkg;

    //////////////////////////////////////////////////
    // Sizes and timing
    //////////////////////////////////////////////////

    // Operand and result width
    localparam int DATA_W = 32;

    // Cycles from the start strobe to the done pulse
    localparam int ICU_LATENCY = 4;

    // Default entries in each lane queue
    localparam int QUEUE_DEPTH = 4;

    //////////////////////////////////////////////////
    // Operation encoding
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        // Low 32 bits of the product
        OP_MUL = 2'd2,
        // Truncates toward zero, x / 0 gives 0
        OP_DIV = 2'd3
    } op_t;

    //////////////////////////////////////////////////
    // Flag bit positions
    //////////////////////////////////////////////////

    // Flag patterns seen by a lane:
    //   0x  result is zero
    //   10  result is positive
    //   11  result is negative
    localparam int FLAG_NZ  = 1;
    localparam int FLAG_NEG = 0;

    //////////////////////////////////////////////////
    // Queued request
    //////////////////////////////////////////////////

    // One lane operation, 2 + 32 + 32 bits
    typedef struct packed {
        op_t                      op;
        logic signed [DATA_W-1:0] a;
        logic signed [DATA_W-1:0] b;
    } icu_req_t;

endpackage

/* hdl/op_fifo.sv */
//////////////////////////////////////////////////
// Lane request queue
// Circular buffer of ICU requests with full/empty
//////////////////////////////////////////////////

`timescale 1ns/1ps

module op_fifo #(
    parameter int DEPTH = icu_pkg::QUEUE_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  icu_pkg::icu_req_t push_data,
    input  logic              pop,
    output icu_pkg::icu_req_t head,
    output logic              full,
    output logic              empty
);

    import icu_pkg::*;

    typedef logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] ptr_t;
    typedef logic [$clog2(DEPTH + 1)-1:0]                  cnt_t;

    icu_req_t mem [DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    cnt_t     count;
    logic     do_push;
    logic     do_pop;

    // Pointer advance with wrap at DEPTH
    function automatic ptr_t next_ptr(input ptr_t p);
        if (p == ptr_t'(DEPTH - 1)) begin
            return '0;
        end else begin
            return p + 1'b1;
        end
    endfunction

    // Push into a full queue is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == cnt_t'(DEPTH));
    assign empty = (count == '0);

    // Oldest entry always visible at the head
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/icu_arbiter.sv */
//////////////////////////////////////////////////
// Round-robin lane arbiter for the shared ICU
// Starts one request at a time, steers results
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icu_arbiter (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              empty0,
    input  logic                              empty1,
    input  icu_pkg::icu_req_t                 head0,
    input  icu_pkg::icu_req_t                 head1,
    input  logic                              done,
    input  logic signed [icu_pkg::DATA_W-1:0] done_result,
    input  logic [1:0]                        done_flag,
    output logic                              pop0,
    output logic                              pop1,
    output logic                              start,
    output icu_pkg::op_t                      start_op,
    output logic signed [icu_pkg::DATA_W-1:0] start_a,
    output logic signed [icu_pkg::DATA_W-1:0] start_b,
    output logic                              result_valid0,
    output logic                              result_valid1,
    output logic signed [icu_pkg::DATA_W-1:0] result,
    output logic [1:0]                        flag
);

    import icu_pkg::*;

    // Lane of the most recent completion
    logic     last_lane;
    logic     in_flight;
    // Lane that owns the operation in the ICU
    logic     owner;
    logic     pick;
    icu_req_t sel_req;

    //////////////////////////////////////////////////
    // Lane selection
    //////////////////////////////////////////////////

    // Both pending: the lane not served last wins.
    // Otherwise the only non-empty lane, which is lane 1 exactly when lane 0 is empty.
    always_comb begin
        if (!empty0 && !empty1) begin
            pick = ~last_lane;
        end else begin
            pick = empty0;
        end
    end

    assign start = !in_flight && !(empty0 && empty1);
    assign pop0  = start && !pick;
    assign pop1  = start && pick;

    // Head of the chosen queue goes straight to the ICU
    assign sel_req  = pick ? head1 : head0;
    assign start_op = sel_req.op;
    assign start_a  = sel_req.a;
    assign start_b  = sel_req.b;

    //////////////////////////////////////////////////
    // In-flight tracking
    //////////////////////////////////////////////////

    // Lane 0 goes first after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_lane <= 1'b1;
            in_flight <= 1'b0;
            owner     <= 1'b0;
        end else if (start) begin
            in_flight <= 1'b1;
            owner     <= pick;
        end else if (done) begin
            in_flight <= 1'b0;
            last_lane <= owner;
        end
    end

    // Result pulse goes to the owner in the done cycle
    assign result_valid0 = done && in_flight && !owner;
    assign result_valid1 = done && in_flight && owner;
    assign result        = done_result;
    assign flag          = done_flag;

endmodule

/* hdl/icu.sv */
//////////////////////////////////////////////////
// Integer compute unit, fixed four-cycle latency
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icu (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  icu_pkg::op_t                      operation,
    input  logic signed [icu_pkg::DATA_W-1:0] a,
    input  logic signed [icu_pkg::DATA_W-1:0] b,
    output logic                              done,
    output logic signed [icu_pkg::DATA_W-1:0] result,
    output logic [1:0]                        flag
);

    import icu_pkg::*;

    typedef logic [$clog2(ICU_LATENCY)-1:0] cnt_t;

    op_t                        op_q;
    logic signed [DATA_W-1:0]   a_q;
    logic signed [DATA_W-1:0]   b_q;
    logic signed [2*DATA_W-1:0] product;
    logic                       busy;
    cnt_t                       count;

    //////////////////////////////////////////////////
    // Operand capture
    //////////////////////////////////////////////////

    // Latched on the start edge, held until the next start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= OP_ADD;
            a_q  <= '0;
            b_q  <= '0;
        end else if (start) begin
            op_q <= operation;
            a_q  <= a;
            b_q  <= b;
        end
    end

    //////////////////////////////////////////////////
    // Latency counter
    //////////////////////////////////////////////////

    // Start in cycle T loads LATENCY-1, count hits 0 in T+LATENCY
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= cnt_t'(ICU_LATENCY - 1);
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign done = busy && (count == '0);

    //////////////////////////////////////////////////
    // Arithmetic and flags
    //////////////////////////////////////////////////

    assign product = a_q * b_q;

    always_comb begin
        case (op_q)
            OP_ADD: result = a_q + b_q;
            OP_SUB: result = a_q - b_q;
            // Wraps to the low half
            OP_MUL: result = product[DATA_W-1:0];
            default: begin
                // Signed divide truncates toward zero
                if (b_q == '0) begin
                    result = '0;
                end else begin
                    result = a_q / b_q;
                end
            end
        endcase
    end

    always_comb begin
        flag           = '0;
        flag[FLAG_NZ]  = |result;
        flag[FLAG_NEG] = result[DATA_W-1];
    end

endmodule

/* hdl/icu_cluster.sv */
//////////////////////////////////////////////////
// Two-lane integer execution cluster
// Lane queues, round-robin arbiter and shared ICU
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icu_cluster (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              issue0,
    input  icu_pkg::op_t                      op0,
    input  logic signed [icu_pkg::DATA_W-1:0] a0,
    input  logic signed [icu_pkg::DATA_W-1:0] b0,
    input  logic                              issue1,
    input  icu_pkg::op_t                      op1,
    input  logic signed [icu_pkg::DATA_W-1:0] a1,
    input  logic signed [icu_pkg::DATA_W-1:0] b1,
    output logic                              full0,
    output logic                              full1,
    output logic                              result_valid0,
    output logic signed [icu_pkg::DATA_W-1:0] result0,
    output logic [1:0]                        flag0,
    output logic                              result_valid1,
    output logic signed [icu_pkg::DATA_W-1:0] result1,
    output logic [1:0]                        flag1
);

    import icu_pkg::*;

    icu_req_t                 req0;
    icu_req_t                 req1;
    icu_req_t                 head0;
    icu_req_t                 head1;
    logic                     empty0;
    logic                     empty1;
    logic                     pop0;
    logic                     pop1;
    logic                     start;
    op_t                      start_op;
    logic signed [DATA_W-1:0] start_a;
    logic signed [DATA_W-1:0] start_b;
    logic                     done;
    logic signed [DATA_W-1:0] icu_result;
    logic [1:0]               icu_flag;
    logic signed [DATA_W-1:0] lane_result;
    logic [1:0]               lane_flag;

    // Lane inputs packed into queue entries
    assign req0 = '{op: op0, a: a0, b: b0};
    assign req1 = '{op: op1, a: a1, b: b1};

    //////////////////////////////////////////////////
    // Lane queues
    //////////////////////////////////////////////////

    op_fifo #(.DEPTH(QUEUE_DEPTH)) u_fifo0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (issue0),
        .push_data (req0),
        .pop       (pop0),
        .head      (head0),
        .full      (full0),
        .empty     (empty0)
    );

    op_fifo #(.DEPTH(QUEUE_DEPTH)) u_fifo1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (issue1),
        .push_data (req1),
        .pop       (pop1),
        .head      (head1),
        .full      (full1),
        .empty     (empty1)
    );

    //////////////////////////////////////////////////
    // Arbiter and compute unit
    //////////////////////////////////////////////////

    icu_arbiter u_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .empty0        (empty0),
        .empty1        (empty1),
        .head0         (head0),
        .head1         (head1),
        .done          (done),
        .done_result   (icu_result),
        .done_flag     (icu_flag),
        .pop0          (pop0),
        .pop1          (pop1),
        .start         (start),
        .start_op      (start_op),
        .start_a       (start_a),
        .start_b       (start_b),
        .result_valid0 (result_valid0),
        .result_valid1 (result_valid1),
        .result        (lane_result),
        .flag          (lane_flag)
    );

    icu u_icu (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .operation (start_op),
        .a         (start_a),
        .b         (start_b),
        .done      (done),
        .result    (icu_result),
        .flag      (icu_flag)
    );

    // Shared result bus, qualified per lane by result_valid
    assign result0 = lane_result;
    assign result1 = lane_result;
    assign flag0   = lane_flag;
    assign flag1   = lane_flag;

endmodule

/* verif/icu_cluster_checker.sv */
//////////////////////////////////////////////////
// Cluster protocol checker
// ICU timing, arbitration and queue rules
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icu_cluster_checker (
    input logic clk,
    input logic rst_n,
    input logic issue0,
    input logic full0,
    input logic issue1,
    input logic full1,
    input logic start,
    input logic done,
    input logic pop0,
    input logic pop1,
    input logic result_valid0,
    input logic result_valid1
);

    import icu_pkg::*;

    // Own view of the ICU occupancy, start to done
    logic busy;

    // Number of failed assertions so far
    int fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // ICU timing
    //////////////////////////////////////////////////

    a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##ICU_LATENCY done)
        else begin
            $error("done missing ICU_LATENCY cycles after start");
            fail_count++;
        end

    a_start_before_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(start, ICU_LATENCY))
        else begin
            $error("done without a start ICU_LATENCY cycles earlier");
            fail_count++;
        end

    a_no_start_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy)
        else begin
            $error("start while an operation is in flight");
            fail_count++;
        end

    //////////////////////////////////////////////////
    // Arbitration and queues
    //////////////////////////////////////////////////

    a_one_pop: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop0 && pop1))
        else begin
            $error("both queues popped in one cycle");
            fail_count++;
        end

    a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
        !(result_valid0 && result_valid1))
        else begin
            $error("result steered to both lanes");
            fail_count++;
        end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(issue0 && full0) && !(issue1 && full1))
        else begin
            $error("issue into a full lane queue");
            fail_count++;
        end

endmodule

// Bound at the top, where queue and arbiter signals meet
bind icu_cluster icu_cluster_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue0        (issue0),
    .full0         (full0),
    .issue1        (issue1),
    .full1         (full1),
    .start         (start),
    .done          (done),
    .pop0          (pop0),
    .pop1          (pop1),
    .result_valid0 (result_valid0),
    .result_valid1 (result_valid1)
);

/* verif/icu_cluster_tb.sv */
//////////////////////////////////////////////////
// Testbench for the two-lane ICU cluster
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icu_cluster_tb;

    import icu_pkg::*;

    localparam int FIXED_ROWS     = 20;
    localparam int NUM_ROWS       = FIXED_ROWS + QUEUE_DEPTH + 1;
    localparam int TIMEOUT_CYCLES = 6 * NUM_ROWS * 5 + 100;

    logic                     clk;
    logic                     rst_n;
    logic                     issue0;
    op_t                      op0;
    logic signed [DATA_W-1:0] a0;
    logic signed [DATA_W-1:0] b0;
    logic                     issue1;
    op_t                      op1;
    logic signed [DATA_W-1:0] a1;
    logic signed [DATA_W-1:0] b1;
    logic                     full0;
    logic                     full1;
    logic                     result_valid0;
    logic signed [DATA_W-1:0] result0;
    logic [1:0]               flag0;
    logic                     result_valid1;
    logic signed [DATA_W-1:0] result1;
    logic [1:0]               flag1;

    // Stimulus table, one row per operation
    int                       row_lane [NUM_ROWS];
    op_t                      row_op   [NUM_ROWS];
    logic signed [DATA_W-1:0] row_a    [NUM_ROWS];
    logic signed [DATA_W-1:0] row_b    [NUM_ROWS];
    logic [DATA_W-1:0]        row_res  [NUM_ROWS];
    logic [1:0]               row_flag [NUM_ROWS];

    // Expected {result, flag} per lane, in issue order
    logic [DATA_W+1:0] sb0 [$];
    logic [DATA_W+1:0] sb1 [$];

    integer seed;
    int     cycle_count;
    logic   rr_check;
    logic   next_lane;
    logic   saw_full0;
    logic   saw_full1;

    icu_cluster u_icu_cluster (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_protocol();
        assert (u_icu_cluster.u_checker.fail_count == 0)
            else stop_on_error("a bound protocol assertion failed");
    endtask

    //////////////////////////////////////////////////
    // Reference arithmetic
    //////////////////////////////////////////////////

    function automatic logic [DATA_W-1:0] expected_result(input op_t op,
            input logic signed [DATA_W-1:0] a, input logic signed [DATA_W-1:0] b);
        logic signed [2*DATA_W-1:0] prod;
        logic [DATA_W:0]            mag_a;
        logic [DATA_W:0]            mag_b;
        logic [DATA_W:0]            quot;
        prod  = a * b;
        mag_a = (a < 0) ? -{1'b1, a} : {1'b0, a};
        mag_b = (b < 0) ? -{1'b1, b} : {1'b0, b};
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_MUL: return prod[DATA_W-1:0];
            default: begin
                if (b == 0) begin
                    return '0;
                end
                // Magnitude divide, sign applied afterwards
                quot = mag_a / mag_b;
                return ((a < 0) != (b < 0)) ? -quot[DATA_W-1:0] : quot[DATA_W-1:0];
            end
        endcase
    endfunction

    function automatic logic [1:0] expected_flag(input logic [DATA_W-1:0] res);
        return {res != '0, res[DATA_W-1]};
    endfunction

    task automatic set_row(input int idx, input int lane, input op_t op,
            input logic signed [DATA_W-1:0] a, input logic signed [DATA_W-1:0] b,
            input logic [DATA_W-1:0] res, input logic [1:0] flag);
        row_lane[idx] = lane;
        row_op[idx]   = op;
        row_a[idx]    = a;
        row_b[idx]    = b;
        row_res[idx]  = res;
        row_flag[idx] = flag;
    endtask

    // Lanes alternate so both queues fill in step
    task automatic load_table();
        set_row(0,  0, OP_ADD, 5,             7,             32'h0000000c, 2'b10);
        set_row(1,  1, OP_ADD, -3,            3,             32'h00000000, 2'b00);
        set_row(2,  0, OP_SUB, 10,            25,            32'hfffffff1, 2'b11);
        set_row(3,  1, OP_SUB, 100,           1,             32'h00000063, 2'b10);
        set_row(4,  0, OP_MUL, -6,            7,             32'hffffffd6, 2'b11);
        set_row(5,  1, OP_MUL, 32'h00010000,  32'h00010000,  32'h00000000, 2'b00);
        set_row(6,  0, OP_MUL, 32'h7fffffff,  2,             32'hfffffffe, 2'b11);
        set_row(7,  1, OP_MUL, 32'h12345678,  32'h00000010,  32'h23456780, 2'b10);
        set_row(8,  0, OP_DIV, 7,             2,             32'h00000003, 2'b10);
        set_row(9,  1, OP_DIV, -7,            2,             32'hfffffffd, 2'b11);
        set_row(10, 0, OP_DIV, 7,             -2,            32'hfffffffd, 2'b11);
        set_row(11, 1, OP_DIV, -7,            -2,            32'h00000003, 2'b10);
        set_row(12, 0, OP_DIV, 1234,          0,             32'h00000000, 2'b00);
        set_row(13, 1, OP_DIV, -5,            0,             32'h00000000, 2'b00);
        set_row(14, 0, OP_ADD, 32'h7fffffff,  1,             32'h80000000, 2'b11);
        set_row(15, 1, OP_SUB, 32'h80000000,  1,             32'h7fffffff, 2'b10);
        set_row(16, 0, OP_DIV, 3,             5,             32'h00000000, 2'b00);
        set_row(17, 1, OP_DIV, -100,          7,             32'hfffffff2, 2'b11);
        set_row(18, 0, OP_SUB, 0,             0,             32'h00000000, 2'b00);
        set_row(19, 1, OP_MUL, -1,            -1,            32'h00000001, 2'b10);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Each cycle issues the next pending row of each lane unless it is full
    task automatic apply_rows(input int first, input int last);
        int pend0 [$];
        int pend1 [$];
        int r;
        for (int i = first; i <= last; i++) begin
            if (row_lane[i] == 0) pend0.push_back(i);
            else pend1.push_back(i);
        end
        while (pend0.size() > 0 || pend1.size() > 0) begin
            @(posedge clk);
            #1;
            issue0 = 1'b0;
            issue1 = 1'b0;
            if (pend0.size() > 0 && !full0) begin
                r      = pend0.pop_front();
                issue0 = 1'b1;
                op0    = row_op[r];
                a0     = row_a[r];
                b0     = row_b[r];
                sb0.push_back({row_res[r], row_flag[r]});
            end
            if (pend1.size() > 0 && !full1) begin
                r      = pend1.pop_front();
                issue1 = 1'b1;
                op1    = row_op[r];
                a1     = row_a[r];
                b1     = row_b[r];
                sb1.push_back({row_res[r], row_flag[r]});
            end
        end
        @(posedge clk);
        #1;
        issue0 = 1'b0;
        issue1 = 1'b0;
    endtask

    task automatic wait_drain();
        while (sb0.size() > 0 || sb1.size() > 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
        assert (!full0 && !full1)
            else stop_on_error("a full output stayed high after the queues drained");
    endtask

    task automatic check_idle_outputs();
        assert (!full0 && !full1 && !result_valid0 && !result_valid1)
            else stop_on_error("full or result_valid high before the first issue");
    endtask

    //////////////////////////////////////////////////
    // Result monitor
    //////////////////////////////////////////////////

    task automatic note_completion(input int lane, input logic [DATA_W-1:0] got_res,
            input logic [1:0] got_flag);
        logic [DATA_W+1:0] exp;
        assert ((lane == 0) ? (sb0.size() > 0) : (sb1.size() > 0))
            else stop_on_error($sformatf("unexpected result on lane %0d", lane));
        if (lane == 0) exp = sb0.pop_front();
        else exp = sb1.pop_front();
        assert (got_res == exp[DATA_W+1:2])
            else stop_on_error($sformatf("ERR result%0d got %h exp %h",
                lane, got_res, exp[DATA_W+1:2]));
        assert (got_flag == exp[1:0])
            else stop_on_error($sformatf("ERR flag%0d got %h exp %h",
                lane, got_flag, exp[1:0]));
        if (rr_check) begin
            assert (lane == int'(next_lane))
                else stop_on_error($sformatf("lane %0d completed out of round-robin turn",
                    lane));
            next_lane = ~next_lane;
        end
    endtask

    // Mid-cycle sampling, outputs are settled here
    always @(negedge clk) begin
        if (rst_n) begin
            check_protocol();
            if (full0) saw_full0 = 1'b1;
            if (full1) saw_full1 = 1'b1;
            if (result_valid0) note_completion(0, result0, flag0);
            if (result_valid1) note_completion(1, result1, flag1);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error("timeout, expected results did not arrive");
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        logic signed [DATA_W-1:0] ra;
        logic signed [DATA_W-1:0] rb;
        op_t                      rop;
        rst_n       = 1'b0;
        issue0      = 1'b0;
        op0         = OP_ADD;
        a0          = '0;
        b0          = '0;
        issue1      = 1'b0;
        op1         = OP_ADD;
        a1          = '0;
        b1          = '0;
        seed        = 32'hd5d2;
        cycle_count = 0;
        rr_check    = 1'b1;
        next_lane   = 1'b0;
        saw_full0   = 1'b0;
        saw_full1   = 1'b0;
        load_table();
        repeat (5) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end

        // Both lanes busy, strict alternation from lane 0
        apply_rows(0, FIXED_ROWS - 1);
        wait_drain();
        assert (saw_full0) else stop_on_error("lane 0 queue never reported full");
        assert (saw_full1) else stop_on_error("lane 1 queue never reported full");

        // Random rows, lane 1 only, one more than the queue holds
        for (int i = FIXED_ROWS; i < NUM_ROWS; i++) begin
            ra  = $random(seed);
            rb  = $random(seed);
            rop = op_t'(i % 4);
            if (rop == OP_DIV && ra == 32'h80000000 && rb == -1) rb = 1;
            set_row(i, 1, rop, ra, rb, expected_result(rop, ra, rb),
                expected_flag(expected_result(rop, ra, rb)));
        end
        rr_check  = 1'b0;
        saw_full1 = 1'b0;
        apply_rows(FIXED_ROWS, NUM_ROWS - 1);
        wait_drain();
        assert (saw_full1) else stop_on_error("lane 1 queue never reported full");
        check_protocol();
        $display("Test OK");
        $finish;
    end

endmodule

/* filelist.f */
hdl/icu_pkg.sv
hdl/op_fifo.sv
hdl/icu_arbiter.sv
hdl/icu.sv
hdl/icu_cluster.sv
verif/icu_cluster_checker.sv
verif/icu_cluster_tb.sv
